//--- hdl/rv_pkg.sv
package rv_pkg;

  // ======================================================================
  // Data and index types
  // ======================================================================
  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0]      reg_idx_t;

  // ======================================================================
  // Opcodes and function codes
  // ======================================================================
  localparam logic [6:0] opc_op     = 7'b0110011;  // Register-register
  localparam logic [6:0] opc_op_imm = 7'b0010011;  // Register-immediate

  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  // Selects sub instead of add, sra instead of srl
  localparam logic [6:0] funct7_alt = 7'b0100000;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_e;

  // ======================================================================
  // Instruction word views
  // ======================================================================
  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } i_type_t;

  typedef union packed {
    r_type_t r;
    i_type_t i;
  } instr_u;

endpackage

//--- hdl/instr_intake.sv
module instr_intake #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        in_valid,
  input  logic [31:0] in_instr,
  input  logic        pop,
  output logic        in_credit,
  output logic        head_valid,
  output logic [31:0] head_instr
);

  localparam int PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CW = $clog2(FIFO_DEPTH + 1);

  logic [31:0]   mem [FIFO_DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          in_valid_q;
  logic [31:0]   in_instr_q;

  // Wraps at FIFO_DEPTH, which need not be a power of two
  function automatic logic [PW-1:0] ptr_next(input logic [PW-1:0] ptr);
    return (ptr == PW'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Input stage register in front of the queue
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      in_valid_q <= 1'b0;
    end else begin
      in_valid_q <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      in_instr_q <= in_instr;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid_q) begin
      mem[wr_ptr] <= in_instr_q;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      in_credit <= 1'b0;
    end else begin
      in_credit <= pop;  // One credit back per popped entry
      if (in_valid_q) wr_ptr <= ptr_next(wr_ptr);
      if (pop) rd_ptr <= ptr_next(rd_ptr);
      case ({in_valid_q, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign head_valid = (count != '0);
  assign head_instr = mem[rd_ptr];

endmodule

//--- hdl/instr_decoder.sv
module instr_decoder (
  input  rv_pkg::instr_u   instr,
  output rv_pkg::reg_idx_t rs1_idx,
  output rv_pkg::reg_idx_t rs2_idx,
  output rv_pkg::reg_idx_t rd_idx,
  output rv_pkg::word_t    imm,
  output logic             use_imm,
  output rv_pkg::alu_op_e  alu_op,
  output logic             illegal
);

  // Shared funct3 map for both instruction classes
  function automatic rv_pkg::alu_op_e f3_to_op(input logic [2:0] f3,
                                               input logic       sub_sel,
                                               input logic       sra_sel);
    rv_pkg::alu_op_e op;
    case (f3)
      rv_pkg::f3_add_sub: op = sub_sel ? rv_pkg::alu_sub : rv_pkg::alu_add;
      rv_pkg::f3_sll:     op = rv_pkg::alu_sll;
      rv_pkg::f3_slt:     op = rv_pkg::alu_slt;
      rv_pkg::f3_sltu:    op = rv_pkg::alu_sltu;
      rv_pkg::f3_xor:     op = rv_pkg::alu_xor;
      rv_pkg::f3_srl_sra: op = sra_sel ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      rv_pkg::f3_or:      op = rv_pkg::alu_or;
      default:            op = rv_pkg::alu_and;
    endcase
    return op;
  endfunction

  logic r_alt;   // funct7 carries the alternate encoding
  logic i_alt;   // Upper immediate bits carry it
  logic i_zero;

  assign r_alt  = (instr.r.funct7 == rv_pkg::funct7_alt);
  assign i_alt  = (instr.i.imm[11:5] == rv_pkg::funct7_alt);
  assign i_zero = (instr.i.imm[11:5] == 7'b0);

  always_comb begin
    rs1_idx = instr.r.rs1;
    rs2_idx = instr.r.rs2;
    rd_idx  = instr.r.rd;
    imm     = {{20{instr.i.imm[11]}}, instr.i.imm};
    use_imm = 1'b0;
    alu_op  = rv_pkg::alu_add;
    illegal = 1'b0;

    case (instr.r.opcode)
      rv_pkg::opc_op: begin
        alu_op = f3_to_op(instr.r.funct3, r_alt, r_alt);
        if (r_alt) begin
          // Only add/sub and srl/sra have an alternate form
          illegal = (instr.r.funct3 != rv_pkg::f3_add_sub) &&
                    (instr.r.funct3 != rv_pkg::f3_srl_sra);
        end else if (instr.r.funct7 != 7'b0) begin
          illegal = 1'b1;
        end
      end
      rv_pkg::opc_op_imm: begin
        use_imm = 1'b1;
        alu_op  = f3_to_op(instr.i.funct3, 1'b0, i_alt);
        if (instr.i.funct3 == rv_pkg::f3_sll) begin
          illegal = !i_zero;
        end else if (instr.i.funct3 == rv_pkg::f3_srl_sra) begin
          illegal = !(i_zero || i_alt);
        end
      end
      default: illegal = 1'b1;
    endcase
  end

endmodule

//--- hdl/register_file.sv
module register_file (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             rd_we,
  input  rv_pkg::reg_idx_t rd_idx,
  input  rv_pkg::word_t    rd_data,
  input  rv_pkg::reg_idx_t rs1_idx,
  input  rv_pkg::reg_idx_t rs2_idx,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data
);

  rv_pkg::word_t regs [31:1];  // x0 has no storage

  assign rs1_data = (rs1_idx != 5'd0) ? regs[rs1_idx] : '0;
  assign rs2_data = (rs2_idx != 5'd0) ? regs[rs2_idx] : '0;

  // Falling-edge write, visible to the reads of the next cycle
  always_ff @(negedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int r = 1; r < 32; r++) begin
        regs[r] <= '0;
      end
    end else if (rd_we && rd_idx != 5'd0) begin
      regs[rd_idx] <= rd_data;
    end
  end

endmodule

//--- hdl/alu.sv
module alu (
  input  rv_pkg::alu_op_e op,
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  output rv_pkg::word_t   result
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = b[4:0];
  assign lt_signed   = ($signed(a) < $signed(b));
  assign lt_unsigned = (a < b);

  always_comb begin
    case (op)
      rv_pkg::alu_add:  result = a + b;
      rv_pkg::alu_sub:  result = a - b;
      rv_pkg::alu_sll:  result = a << shamt;
      rv_pkg::alu_slt:  result = {31'b0, lt_signed};
      rv_pkg::alu_sltu: result = {31'b0, lt_unsigned};
      rv_pkg::alu_xor:  result = a ^ b;
      rv_pkg::alu_srl:  result = a >> shamt;
      rv_pkg::alu_sra:  result = $signed(a) >>> shamt;  // Sign bit fills from the left
      rv_pkg::alu_or:   result = a | b;
      rv_pkg::alu_and:  result = a & b;
      default:          result = '0;
    endcase
  end

endmodule

//--- hdl/result_port.sv
module result_port #(
  parameter int OUT_CREDITS = 2
) (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             head_valid,
  input  rv_pkg::reg_idx_t rd_idx,
  input  rv_pkg::word_t    alu_result,
  input  logic             illegal,
  input  logic             out_credit,
  output logic             issue,
  output logic             out_valid,
  output rv_pkg::reg_idx_t out_rd,
  output rv_pkg::word_t    out_data,
  output logic             out_illegal
);

  localparam int CW = $clog2(OUT_CREDITS + 1);

  logic [CW-1:0] credit_cnt;
  rv_pkg::word_t result_hold;  // Result as computed from the source registers

  // Issue only with a queued instruction and a consumer credit
  assign issue = head_valid && (credit_cnt != '0);

  // ======================================================================
  // Consumer credit counter
  // ======================================================================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      credit_cnt <= CW'(OUT_CREDITS);
      out_valid  <= 1'b0;
    end else begin
      out_valid <= issue;
      case ({out_credit, issue})
        2'b10:   credit_cnt <= credit_cnt + 1'b1;
        2'b01:   credit_cnt <= credit_cnt - 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  // Taken at the same falling edge as the write-back, before rd can change a source
  always_ff @(negedge clk) begin
    if (issue) begin
      result_hold <= illegal ? '0 : alu_result;
    end
  end

  // Result register
  always_ff @(posedge clk) begin
    if (issue) begin
      out_rd      <= rd_idx;
      out_illegal <= illegal;
      out_data    <= result_hold;
    end
  end

endmodule

//--- hdl/rv_exec_top.sv
module rv_exec_top #(
  parameter int FIFO_DEPTH  = 4,
  parameter int OUT_CREDITS = 2
) (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             in_valid,
  input  logic [31:0]      in_instr,
  output logic             in_credit,
  output logic             out_valid,
  output rv_pkg::reg_idx_t out_rd,
  output rv_pkg::word_t    out_data,
  output logic             out_illegal,
  input  logic             out_credit
);

  logic             head_valid;
  logic [31:0]      head_instr;
  logic             issue;
  rv_pkg::reg_idx_t rs1_idx;
  rv_pkg::reg_idx_t rs2_idx;
  rv_pkg::reg_idx_t rd_idx;
  rv_pkg::word_t    imm;
  logic             use_imm;
  rv_pkg::alu_op_e  alu_op;
  logic             illegal;
  rv_pkg::word_t    rs1_data;
  rv_pkg::word_t    rs2_data;
  rv_pkg::word_t    alu_result;

  instr_intake #(.FIFO_DEPTH(FIFO_DEPTH)) u_intake (
    .clk, .arst_n, .in_valid, .in_instr, .pop(issue),
    .in_credit, .head_valid, .head_instr
  );

  instr_decoder u_decoder (
    .instr(rv_pkg::instr_u'(head_instr)),
    .rs1_idx, .rs2_idx, .rd_idx, .imm, .use_imm, .alu_op, .illegal
  );

  register_file u_regfile (
    .clk, .arst_n, .rd_we(issue && !illegal), .rd_idx, .rd_data(alu_result),
    .rs1_idx, .rs2_idx, .rs1_data, .rs2_data
  );

  alu u_alu (
    .op(alu_op), .a(rs1_data), .b(use_imm ? imm : rs2_data), .result(alu_result)
  );

  result_port #(.OUT_CREDITS(OUT_CREDITS)) u_result (
    .clk, .arst_n, .head_valid, .rd_idx, .alu_result, .illegal, .out_credit,
    .issue, .out_valid, .out_rd, .out_data, .out_illegal
  );

endmodule

//--- verification/tb_rv_exec_sva.sv
module tb_rv_exec_sva #(
  parameter int FIFO_DEPTH  = 4,
  parameter int OUT_CREDITS = 2
) (
  input logic clk,
  input logic arst_n,
  input logic in_valid,
  input logic in_credit,
  input logic out_valid,
  input logic out_credit
);

  int queued;   // Sender credits spent and not yet returned
  int credits;  // Consumer credits still held by the DUT

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      queued  <= 0;
      credits <= OUT_CREDITS;
    end else begin
      queued  <= queued + int'(in_valid) - int'(in_credit);
      credits <= credits + int'(out_credit) - int'(out_valid);
    end
  end

  a_out_needs_credit: assert property (
    @(posedge clk) disable iff (!arst_n) out_valid |-> credits > 0
  ) else $error("out_valid raised while the DUT held no consumer credit");

  a_in_not_full: assert property (
    @(posedge clk) disable iff (!arst_n) in_valid |-> queued < FIFO_DEPTH
  ) else $error("in_valid sent into a full intake queue");

  a_reset_quiet: assert property (
    @(posedge clk) !arst_n |-> !out_valid && !in_credit
  ) else $error("Port strobes active during reset");

endmodule

bind rv_exec_top tb_rv_exec_sva #(
  .FIFO_DEPTH(FIFO_DEPTH),
  .OUT_CREDITS(OUT_CREDITS)
) u_sva (
  .clk(clk),
  .arst_n(arst_n),
  .in_valid(in_valid),
  .in_credit(in_credit),
  .out_valid(out_valid),
  .out_credit(out_credit)
);

//--- verification/tb_rv_exec.sv
module tb_rv_exec;

  localparam int FIFO_DEPTH       = 4;
  localparam int OUT_CREDITS      = 2;
  localparam int drive_dly        = 2;
  localparam int max_instr        = 200;  // Upper bound on instructions over all tests
  localparam int cycles_per_instr = 24;

  logic             clk;
  logic             arst_n;
  logic             in_valid;
  logic [31:0]      in_instr;
  logic             in_credit;
  logic             out_valid;
  rv_pkg::reg_idx_t out_rd;
  rv_pkg::word_t    out_data;
  logic             out_illegal;
  logic             out_credit;

  rv_pkg::word_t ref_regs [32];  // Reference register state in issue order
  logic [4:0]    exp_rd [$];
  rv_pkg::word_t exp_data [$];
  logic          exp_ill [$];
  int            sent_count;
  int            credits_rx;
  int            results_rx;
  int            credits_back;
  logic          bp_mode;
  logic [31:0]   stim_rng;
  logic [31:0]   gap_rng;

  rv_exec_top #(
    .FIFO_DEPTH(FIFO_DEPTH),
    .OUT_CREDITS(OUT_CREDITS)
  ) u_dut (
    .clk(clk),
    .arst_n(arst_n),
    .in_valid(in_valid),
    .in_instr(in_instr),
    .in_credit(in_credit),
    .out_valid(out_valid),
    .out_rd(out_rd),
    .out_data(out_data),
    .out_illegal(out_illegal),
    .out_credit(out_credit)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ====================================================================
  // Helpers
  // ====================================================================
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand_word();
    stim_rng = xorshift(stim_rng);
    return stim_rng;
  endfunction

  function automatic logic [31:0] r_type_word(input logic [6:0] f7, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3,
                                              input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rv_pkg::opc_op};
  endfunction

  function automatic logic [31:0] i_type_word(input logic [11:0] imm, input logic [4:0] rs1,
                                              input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, rv_pkg::opc_op_imm};
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // RV32I OP / OP-IMM rules, queued as the expected result
  task automatic model_issue(input logic [31:0] ins);
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic        alt;
    logic        bad;
    opc = ins[6:0];
    f3  = ins[14:12];
    f7  = ins[31:25];
    rd  = ins[11:7];
    a   = ref_regs[ins[19:15]];
    b   = (opc == rv_pkg::opc_op_imm) ? {{20{ins[31]}}, ins[31:20]} : ref_regs[ins[24:20]];
    alt = (f7 == 7'b0100000);
    bad = 1'b0;
    if (opc == rv_pkg::opc_op) begin
      bad = (f7 != 7'd0) && !(alt && (f3 == 3'b000 || f3 == 3'b101));
    end else if (opc == rv_pkg::opc_op_imm) begin
      if (f3 == 3'b001) bad = (f7 != 7'd0);
      if (f3 == 3'b101) bad = (f7 != 7'd0) && !alt;
      if (f3 == 3'b000) alt = 1'b0;  // addi has no subtract form
    end else begin
      bad = 1'b1;
    end
    case (f3)
      3'b000:  res = alt ? a - b : a + b;
      3'b001:  res = a << b[4:0];
      3'b010:  res = {31'b0, $signed(a) < $signed(b)};
      3'b011:  res = {31'b0, a < b};
      3'b100:  res = a ^ b;
      3'b101: begin
        if (alt) res = $signed(a) >>> b[4:0];
        else res = a >> b[4:0];
      end
      3'b110:  res = a | b;
      default: res = a & b;
    endcase
    if (bad) res = 32'd0;
    exp_rd.push_back(rd);
    exp_data.push_back(res);
    exp_ill.push_back(bad);
    if (!bad && rd != 5'd0) ref_regs[rd] = res;
  endtask

  task automatic send_instr(input logic [31:0] ins);
    while (FIFO_DEPTH + credits_rx - sent_count <= 0) begin  // Wait for a sender credit
      @(posedge clk);
      #drive_dly;
    end
    if (sent_count >= max_instr) abort_run("Test sent more instructions than budgeted");
    model_issue(ins);
    in_valid = 1'b1;
    in_instr = ins;
    sent_count++;
    @(posedge clk);
    #drive_dly;
    in_valid = 1'b0;
  endtask

  task automatic wait_idle();
    while (exp_rd.size() != 0) begin
      @(posedge clk);
      #drive_dly;
    end
  endtask

  // ====================================================================
  // Result monitor and consumer model
  // ====================================================================
  always @(negedge clk) begin : monitor
    logic [4:0]    e_rd;
    rv_pkg::word_t e_data;
    logic          e_ill;
    if (in_credit) credits_rx++;
    if (out_valid) begin
      if (exp_rd.size() == 0) abort_run("A result appeared with no instruction outstanding");
      e_rd   = exp_rd.pop_front();
      e_data = exp_data.pop_front();
      e_ill  = exp_ill.pop_front();
      check_value("out_rd", 32'(out_rd), 32'(e_rd));
      check_value("out_illegal", 32'(out_illegal), 32'(e_ill));
      check_value("out_data", out_data, e_data);
      results_rx++;
    end
  end

  initial begin : consumer
    int gap;
    gap = 0;
    out_credit = 1'b0;
    forever begin
      @(posedge clk);
      #drive_dly;
      out_credit = 1'b0;
      if (gap > 0) begin
        gap--;
      end else if (credits_back < results_rx) begin
        out_credit = 1'b1;
        credits_back++;
        if (bp_mode) begin  // Hold the next credit back a random while
          gap_rng = xorshift(gap_rng);
          gap = int'(gap_rng[3:0]);
        end
      end
    end
  end

  initial begin : watchdog
    repeat (16 + max_instr * cycles_per_instr) @(posedge clk);
    abort_run("Timeout: the DUT stopped returning results");
  end

  // ====================================================================
  // Directed tests
  // ====================================================================
  task automatic test_reset_state();
    repeat (4) begin
      check_value("out_valid", {31'b0, out_valid}, 32'h0);
      check_value("in_credit", {31'b0, in_credit}, 32'h0);
      @(posedge clk);
      #drive_dly;
    end
    for (int r = 0; r < 32; r++) send_instr(r_type_word(7'h00, 5'd0, 5'(r), 3'b000, 5'd0));
    wait_idle();
  endtask

  task automatic test_imm_ops();
    logic [31:0] v;
    logic [4:0]  rd;
    logic [11:0] imm;
    logic [2:0]  f3;
    for (int k = 1; k <= 4; k++) begin
      v = rand_word();
      send_instr(i_type_word(v[11:0], 5'd0, 3'b000, 5'(k)));
    end
    for (int round = 0; round < 4; round++) begin
      for (int f = 0; f < 9; f++) begin
        v   = rand_word();
        rd  = (v[25:21] == 5'd0) ? 5'd1 : v[25:21];
        imm = v[11:0];
        if (round == 0) imm[11] = 1'b1;  // Negative immediates first
        case (f)
          0: f3 = 3'b000;
          1: f3 = 3'b010;
          2: f3 = 3'b011;
          3: f3 = 3'b100;
          4: f3 = 3'b110;
          5: f3 = 3'b111;
          6: begin
            f3  = 3'b001;
            imm = {7'h00, v[4:0]};
          end
          7: begin
            f3  = 3'b101;
            imm = {7'h00, v[4:0]};
          end
          default: begin
            f3  = 3'b101;
            imm = {7'h20, v[4:0]};
          end
        endcase
        send_instr(i_type_word(imm, v[20:16], f3, rd));
      end
    end
    wait_idle();
  endtask

  task automatic test_reg_ops();
    logic [31:0] v;
    logic [4:0]  prev;
    logic [9:0]  fn;
    for (int round = 0; round < 2; round++) begin
      v = rand_word();
      send_instr(i_type_word(v[11:0], 5'd0, 3'b000, 5'd10));
      send_instr(i_type_word(12'd13, 5'd10, 3'b001, 5'd11));
      send_instr(i_type_word(v[23:12], 5'd11, 3'b100, 5'd11));
      prev = 5'd11;
      for (int k = 0; k < 10; k++) begin
        case (k)  // {funct7, funct3}
          0: fn = {7'h00, 3'b000};
          1: fn = {7'h20, 3'b000};
          2: fn = {7'h00, 3'b001};
          3: fn = {7'h00, 3'b100};
          4: fn = {7'h00, 3'b101};
          5: fn = {7'h20, 3'b101};
          6: fn = {7'h00, 3'b110};
          7: fn = {7'h00, 3'b111};
          8: fn = {7'h00, 3'b010};
          default: fn = {7'h00, 3'b011};
        endcase
        send_instr(r_type_word(fn[9:3], 5'd10, prev, fn[2:0], 5'(12 + k)));
        prev = 5'(12 + k);
      end
    end
    wait_idle();
  endtask

  task automatic test_x0();
    send_instr(i_type_word(12'h5a5, 5'd0, 3'b000, 5'd0));
    send_instr(r_type_word(7'h00, 5'd10, 5'd10, 3'b000, 5'd0));
    send_instr(r_type_word(7'h00, 5'd0, 5'd0, 3'b110, 5'd5));  // x0 must still read zero
    wait_idle();
  endtask

  task automatic test_illegal();
    send_instr({12'h004, 5'd10, 3'b010, 5'd12, 7'b0000011});  // Load opcode
    send_instr({20'habcde, 5'd13, 7'b1101111});              // JAL opcode
    send_instr(r_type_word(7'h01, 5'd11, 5'd10, 3'b000, 5'd14));
    send_instr(r_type_word(7'h20, 5'd11, 5'd10, 3'b100, 5'd15));
    send_instr(i_type_word({7'h20, 5'd3}, 5'd10, 3'b001, 5'd16));
    for (int k = 0; k < 5; k++) send_instr(r_type_word(7'h00, 5'd0, 5'(12 + k), 3'b000, 5'd0));
    wait_idle();
  endtask

  task automatic test_backpressure();
    logic [31:0] v;
    int          start_sent;
    int          start_credits;
    start_sent    = sent_count;
    start_credits = credits_rx;
    bp_mode = 1'b1;
    for (int n = 0; n < 60; n++) begin
      v = rand_word();
      if (v[0]) begin
        send_instr(r_type_word({1'b0, v[31], 5'd0}, v[24:20], v[19:15], v[14:12], v[11:7]));
      end else begin
        send_instr(i_type_word(v[31:20], v[19:15], v[14:12], v[11:7]));
      end
    end
    wait_idle();
    bp_mode = 1'b0;
    check_value("in_credit pulses", 32'(credits_rx - start_credits), 32'(sent_count - start_sent));
  endtask

  initial begin
    arst_n       = 1'b0;
    in_valid     = 1'b0;
    in_instr     = 32'd0;
    sent_count   = 0;
    credits_rx   = 0;
    results_rx   = 0;
    credits_back = 0;
    bp_mode      = 1'b0;
    stim_rng     = 32'h13ea;
    gap_rng      = 32'h13ea;
    for (int r = 0; r < 32; r++) ref_regs[r] = 32'd0;
    repeat (16) @(posedge clk);
    #drive_dly;
    arst_n = 1'b1;

    test_reset_state();
    test_imm_ops();
    test_reg_ops();
    test_x0();
    test_illegal();
    test_backpressure();

    if (credits_rx == sent_count) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      abort_run("The in_credit pulse count differs from the instructions sent");
    end
  end

endmodule

//--- list.f
hdl/rv_pkg.sv
hdl/instr_intake.sv
hdl/instr_decoder.sv
hdl/register_file.sv
hdl/alu.sv
hdl/result_port.sv
hdl/rv_exec_top.sv
verification/tb_rv_exec_sva.sv
verification/tb_rv_exec.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_exec
RTL_TOP   ?= rv_exec_top
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing -j 0
LINT_SRCS ?= hdl/rv_pkg.sv hdl/instr_intake.sv hdl/instr_decoder.sv \
             hdl/register_file.sv hdl/alu.sv hdl/result_port.sv hdl/rv_exec_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "No pass line found in $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(LINT_SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
